/* rtl/aguCfgPkg.sv */
// widths shared by the address generation stage
package aguCfgPkg;

	// virtual address produced by the unit
	localparam int addrWidth = 48;

	// full register width of base and index operands
	localparam int regWidth = 64;

	// significant index bits before extension
	localparam int idxSrcWidth = 33;

	// displacement field
	localparam int immWidth = 16;

	// one slice of the carry-select adder
	localparam int chunkWidth = 16;

	// bound limit, counted in 16-byte units
	localparam int limitWidth = 28;

	// request sampled at edge N gives a result after edge N+2
	localparam int pipeLatency = 2;

endpackage

/* rtl/aguOpPkg.sv */
// micro-command codes and the payload structs of the stage
package aguOpPkg;
	import aguCfgPkg::*;

	typedef enum logic [5:0]
	{
		cmdLoad  = 6'h01,
		cmdStore = 6'h02,
		cmdLea   = 6'h03
	} aguCmdE;

	// index-extension word, msb first
	typedef struct packed
	{
		logic [1:0] cond;
		logic [1:0] accessType;
		logic       spare;
		logic       useDisp;
		// zero extension instead of sign extension
		logic       zExt;
		// shift by 0..3, i.e. x1, x2, x4, x8
		logic [1:0] scale;
	} aguIxtT;

	typedef struct packed
	{
		logic                  checkEn;
		// region is read-only
		logic                  isConst;
		logic [limitWidth-1:0] limit;
	} aguBoundT;

	typedef struct packed
	{
		logic [regWidth-1:0] base;
		logic [regWidth-1:0] index;
		logic [immWidth-1:0] imm;
		aguCmdE              cmd;
		aguIxtT              ixt;
		// upper address chunk enables
		logic [1:0]          enJq;
		aguBoundT            bound;
	} aguReqT;

	typedef struct packed
	{
		logic [addrWidth-1:0] addr;
		logic                 oob;
	} aguResT;

endpackage

/* rtl/aguStageReg.sv */
`timescale 1ns/1ps

module aguStageReg
#(
	parameter type payloadT = logic
)
(
	input  logic    clock,
	input  logic    rstN,
	input  logic    inValid,
	input  payloadT inData,
	output logic    outValid,
	output payloadT outData
);

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			outValid <= 1'b0;
		end
		else
		begin
			outValid <= inValid;
		end
	end

	// payload holds its last value between items
	always_ff @(posedge clock)
	begin
		if (inValid)
		begin
			outData <= inData;
		end
	end

	validKnown: assert property (@(posedge clock) disable iff (!rstN) !$isunknown(outValid))
	else
		$error("outValid unknown after reset");

endmodule

/* rtl/aguIndexScale.sv */
`timescale 1ns/1ps

module aguIndexScale
	import aguCfgPkg::*, aguOpPkg::*;
(
	input  logic [regWidth-1:0]  index,
	input  logic [immWidth-1:0]  imm,
	input  aguIxtT               ixt,
	output logic [addrWidth-1:0] scaledIdx,
	output logic [addrWidth-1:0] addend
);

	logic [addrWidth-1:0] extIdx;
	logic [addrWidth-1:0] dispExt;
	logic                 fillBit;

	// only the low 33 bits of the index are significant
	always_comb
	begin
		fillBit = ixt.zExt ? 1'b0 : index[idxSrcWidth-1];
		extIdx = {{(addrWidth-idxSrcWidth){fillBit}}, index[idxSrcWidth-1:0]};
	end

	// four shifted copies, top bits fall off
	always_comb
	begin
		case (ixt.scale)
			2'b00:
			begin
				scaledIdx = extIdx;
			end
			2'b01:
			begin
				scaledIdx = {extIdx[addrWidth-2:0], 1'b0};
			end
			2'b10:
			begin
				scaledIdx = {extIdx[addrWidth-3:0], 2'b0};
			end
			default:
			begin
				scaledIdx = {extIdx[addrWidth-4:0], 3'b0};
			end
		endcase
	end

	// displacement is folded in here; the bound check sees scaledIdx only
	always_comb
	begin
		dispExt = {{(addrWidth-immWidth){imm[immWidth-1]}}, imm};
		addend = ixt.useDisp ? (scaledIdx + dispExt) : scaledIdx;
	end

endmodule

/* rtl/aguAddrAdd.sv */
`timescale 1ns/1ps

module aguAddrAdd
	import aguCfgPkg::*;
(
	input  logic [addrWidth-1:0] base,
	input  logic [addrWidth-1:0] addend,
	input  logic [1:0]           enJq,
	output logic [addrWidth-1:0] addr
);

	logic [chunkWidth:0]   sumLo;
	logic [chunkWidth:0]   sumMid0;
	logic [chunkWidth:0]   sumMid1;
	logic [chunkWidth-1:0] sumHi0;
	logic [chunkWidth-1:0] sumHi1;
	logic                  carryMid;
	logic                  carryHi;
	logic [chunkWidth-1:0] midChunk;
	logic [chunkWidth-1:0] hiChunk;
	logic                  upperEn;

	// each upper chunk is summed for both possible carry-ins
	always_comb
	begin
		sumLo = {1'b0, base[chunkWidth-1:0]} + {1'b0, addend[chunkWidth-1:0]};

		sumMid0 = {1'b0, base[2*chunkWidth-1:chunkWidth]}
			+ {1'b0, addend[2*chunkWidth-1:chunkWidth]};
		sumMid1 = {1'b0, base[2*chunkWidth-1:chunkWidth]}
			+ {1'b0, addend[2*chunkWidth-1:chunkWidth]} + 1'b1;

		sumHi0 = base[addrWidth-1:2*chunkWidth] + addend[addrWidth-1:2*chunkWidth];
		sumHi1 = base[addrWidth-1:2*chunkWidth] + addend[addrWidth-1:2*chunkWidth]
			+ 1'b1;
	end

	// carry select, chained from the low chunk upward
	always_comb
	begin
		carryMid = sumLo[chunkWidth];
		midChunk = carryMid ? sumMid1[chunkWidth-1:0] : sumMid0[chunkWidth-1:0];
		carryHi = carryMid ? sumMid1[chunkWidth] : sumMid0[chunkWidth];
		hiChunk = carryHi ? sumHi1 : sumHi0;
	end

	// upper chunk kept for full enable, or for a high-half base when enJq[1]
	always_comb
	begin
		upperEn = enJq[0] || (enJq[1] && (base[addrWidth-1:addrWidth-2] == 2'b11));
		if (upperEn)
		begin
			addr = {hiChunk, midChunk, sumLo[chunkWidth-1:0]};
		end
		else
		begin
			addr = {{chunkWidth{1'b0}}, midChunk, sumLo[chunkWidth-1:0]};
		end
	end

	// carry-select result equals a plain add with the upper chunk masked by the enable
	always_comb
	begin
		addrMatchesSum: assert final (addr == ((base + addend)
			& {{chunkWidth{upperEn}}, {(2*chunkWidth){1'b1}}}))
		else
			$error("address mismatch with enJq=%b base=%h addend=%h", enJq, base, addend);
	end

endmodule

/* rtl/aguBoundCheck.sv */
`timescale 1ns/1ps

module aguBoundCheck
	import aguCfgPkg::*, aguOpPkg::*;
(
	input  logic [addrWidth-1:0] scaledIdx,
	input  aguCmdE               cmd,
	input  aguBoundT             bound,
	output logic                 oob
);

	logic isNeg;
	logic highSet;
	logic overLimit;
	logic constStore;
	logic anyFault;

	always_comb
	begin
		// negative index always faults
		isNeg = scaledIdx[addrWidth-1];

		// beyond 4 GiB of index range
		highSet = (scaledIdx[addrWidth-1:32] != '0);

		// limit counts 16-byte lines
		overLimit = (scaledIdx[31:4] >= bound.limit);

		constStore = bound.isConst && (cmd == cmdStore);

		anyFault = isNeg || highSet || overLimit || constStore;
	end

	// lea only forms an address, so nothing to trap
	always_comb
	begin
		if (cmd == cmdLea)
		begin
			oob = 1'b0;
		end
		else
		begin
			oob = bound.checkEn && anyFault;
		end
	end

	// one wide compare stands in for the sign, high-bit and limit tests
	always_comb
	begin
		oobMatchesRange: assert final (oob == (bound.checkEn && (cmd != cmdLea)
			&& ((bound.isConst && (cmd == cmdStore))
			|| (scaledIdx >= {{(addrWidth-limitWidth-4){1'b0}}, bound.limit, 4'b0}))))
		else
			$error("oob disagrees with the bound rule, cmd=%0d", cmd);
	end

endmodule

/* rtl/aguExecUnit.sv */
`timescale 1ns/1ps

module aguExecUnit
	import aguCfgPkg::*, aguOpPkg::*;
(
	input  logic   clock,
	input  logic   rstN,
	input  logic   reqValid,
	input  aguReqT req,
	output logic   resValid,
	output aguResT res
);

	logic                 stageValid;
	aguReqT               stageReq;
	logic [addrWidth-1:0] scaledIdx;
	logic [addrWidth-1:0] addend;
	logic [addrWidth-1:0] addr;
	logic                 oob;
	aguResT               resNext;

	// input register
	aguStageReg #(
		.payloadT(aguReqT)
	) inStage (
		.clock   (clock),
		.rstN    (rstN),
		.inValid (reqValid),
		.inData  (req),
		.outValid(stageValid),
		.outData (stageReq)
	);

	aguIndexScale indexScale (
		.index    (stageReq.index),
		.imm      (stageReq.imm),
		.ixt      (stageReq.ixt),
		.scaledIdx(scaledIdx),
		.addend   (addend)
	);

	aguAddrAdd addrAdd (
		.base  (stageReq.base[addrWidth-1:0]),
		.addend(addend),
		.enJq  (stageReq.enJq),
		.addr  (addr)
	);

	// bounds use the undisplaced index
	aguBoundCheck boundCheck (
		.scaledIdx(scaledIdx),
		.cmd      (stageReq.cmd),
		.bound    (stageReq.bound),
		.oob      (oob)
	);

	assign resNext = '{addr: addr, oob: oob};

	// output register
	aguStageReg #(
		.payloadT(aguResT)
	) outStage (
		.clock   (clock),
		.rstN    (rstN),
		.inValid (stageValid),
		.inData  (resNext),
		.outValid(resValid),
		.outData (res)
	);

endmodule

/* testbench/tbClockGen.sv */
`timescale 1ns/1ps

module tbClockGen
(
	output logic clock
);

	// 4 ns period
	localparam real halfPeriodNs = 2.0;

	initial
	begin
		clock = 1'b0;
		forever
		begin
			#(halfPeriodNs) clock = ~clock;
		end
	end

endmodule

/* testbench/tbAguExec.sv */
`timescale 1ns/1ps

module tbAguExec
	import aguCfgPkg::*, aguOpPkg::*;
;

	localparam int resetCycles = 8;
	localparam int latencyReqs = 4;
	localparam int scaleReqs = 32;
	localparam int carryReqs = 12;
	localparam int enableReqs = 12;
	localparam int boundReqs = 24;
	localparam int totalReqs = latencyReqs + scaleReqs + carryReqs + enableReqs + boundReqs;
	localparam int cycleLimit = resetCycles + 20 + (3 * totalReqs) / 2;

	logic   clock;
	logic   rstN;
	logic   reqValid;
	aguReqT req;
	logic   resValid;
	aguResT res;

	logic [31:0] rngState;
	aguResT      expQ[$];
	string       nameQ[$];
	aguResT      expHead;
	string       expName;
	logic        expAvail;
	int          valueErrors;
	int          protocolErrors;
	int          cycleCount;

	tbClockGen clockGen (
		.clock(clock)
	);

	aguExecUnit dut (
		.clock   (clock),
		.rstN    (rstN),
		.reqValid(reqValid),
		.req     (req),
		.resValid(resValid),
		.res     (res)
	);

	function automatic logic [31:0] nextRand();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	// expected result straight from the addressing and bound rules
	function automatic aguResT expectResult(input aguReqT r);
		logic signed [idxSrcWidth-1:0] idxSigned;
		logic signed [immWidth-1:0]    immSigned;
		logic [addrWidth-1:0]          ext;
		logic [addrWidth-1:0]          disp;
		logic [addrWidth-1:0]          scaled;
		logic [addrWidth-1:0]          sum;
		logic                          keepUpper;
		logic                          fault;
		aguResT                        e;
		idxSigned = r.index[idxSrcWidth-1:0];
		immSigned = r.imm;
		if (r.ixt.zExt)
		begin
			ext = r.index[idxSrcWidth-1:0];
		end
		else
		begin
			ext = idxSigned;
		end
		scaled = ext << r.ixt.scale;
		disp = immSigned;
		sum = r.base[addrWidth-1:0] + (r.ixt.useDisp ? scaled + disp : scaled);
		keepUpper = r.enJq[0] || (r.enJq[1] && r.base[47:46] == 2'b11);
		if (!keepUpper)
		begin
			sum[47:32] = '0;
		end
		fault = scaled[47] || (|scaled[47:32]) || (scaled[31:4] >= r.bound.limit)
			|| (r.bound.isConst && r.cmd == cmdStore);
		e.addr = sum;
		e.oob = r.bound.checkEn && fault && (r.cmd != cmdLea);
		return e;
	endfunction

	// plain load, full upper enable, no bound check
	function automatic aguReqT randomReq();
		aguReqT r;
		r.base = {nextRand(), nextRand()};
		r.index = {nextRand(), nextRand()};
		r.imm = 16'(nextRand());
		r.cmd = cmdLoad;
		r.ixt = 9'(nextRand());
		r.ixt.useDisp = 1'b0;
		r.enJq = 2'b01;
		r.bound = 30'(nextRand());
		r.bound.checkEn = 1'b0;
		return r;
	endfunction

	// index bits above 32 stay random, they must be ignored
	function automatic aguReqT boundReq(input int k, input aguCmdE cmd);
		aguReqT r;
		r = randomReq();
		r.cmd = cmd;
		r.ixt.scale = 2'b00;
		r.ixt.zExt = 1'b1;
		r.bound.checkEn = 1'b1;
		r.bound.isConst = 1'b0;
		r.bound.limit = 28'h100;
		case (k)
			0: r.index[32:0] = 33'h0FF0;
			1: r.index[32:0] = 33'h1000;
			2:
			begin
				r.index[32:0] = 33'h0400;
				r.ixt.scale = 2'b10;
			end
			3:
			begin
				r.index[32:0] = 33'h1_FFFF_FFF0;
				r.ixt.zExt = 1'b0;
			end
			4: r.index[32:0] = 33'h1_0000_0000;
			5:
			begin
				r.index[32:0] = 33'h0_8000_0000;
				r.ixt.scale = 2'b01;
			end
			6:
			begin
				r.index[32:0] = 33'h0010;
				r.bound.isConst = 1'b1;
			end
			default:
			begin
				r.index[32:0] = 33'h0_FFFF_FFFF;
				r.bound.checkEn = 1'b0;
			end
		endcase
		return r;
	endfunction

	task automatic sendReq(input aguReqT r, input string name);
		@(negedge clock);
		req = r;
		reqValid = 1'b1;
		expQ.push_back(expectResult(r));
		nameQ.push_back(name);
	endtask

	task automatic idleCycles(input int n);
		repeat (n)
		begin
			@(negedge clock);
			reqValid = 1'b0;
			req = '0;
		end
	endtask

	// head of the queue lines up with the result shown until the next edge
	always @(negedge clock)
	begin
		if (resValid && expQ.size() > 0)
		begin
			expHead = expQ.pop_front();
			expName = nameQ.pop_front();
			expAvail = 1'b1;
		end
		else
		begin
			expAvail = 1'b0;
		end
	end

	resetQuiet: assert property (@(posedge clock) !rstN |=> !resValid)
	else
	begin
		protocolErrors++;
		$display("resValid went high during reset");
	end

	latencyExact: assert property (@(posedge clock) disable iff (!rstN)
		reqValid |-> ##pipeLatency resValid)
	else
	begin
		protocolErrors++;
		$display("a request got no result %0d cycles later", pipeLatency);
	end

	noStrayResult: assert property (@(posedge clock) disable iff (!rstN)
		resValid |-> $past(reqValid, pipeLatency))
	else
	begin
		protocolErrors++;
		$display("resValid high without a request %0d cycles before", pipeLatency);
	end

	resultPending: assert property (@(posedge clock) disable iff (!rstN)
		resValid |-> expAvail)
	else
	begin
		protocolErrors++;
		$display("a result arrived with no request pending");
	end

	resultMatch: assert property (@(posedge clock) disable iff (!rstN)
		(resValid && expAvail) |-> (res == expHead))
	else
	begin
		valueErrors++;
		$display("** Error [%s] expected addr=%h oob=%b, actual addr=%h oob=%b",
			expName, expHead.addr, expHead.oob, $sampled(res.addr), $sampled(res.oob));
	end

	initial
	begin
		cycleCount = 0;
		while (cycleCount < cycleLimit)
		begin
			@(posedge clock);
			cycleCount++;
		end
		$display("run stopped after %0d cycles without finishing", cycleLimit);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		aguReqT r;
		rngState = 32'h9648;
		valueErrors = 0;
		protocolErrors = 0;
		expAvail = 1'b0;
		rstN = 1'b0;
		reqValid = 1'b0;
		req = '0;
		repeat (resetCycles) @(negedge clock);
		rstN = 1'b1;
		idleCycles(4);

		for (int i = 0; i < latencyReqs; i++)
		begin
			sendReq(randomReq(), "latency");
		end
		idleCycles(3);

		// each scale, sign and zero extension
		for (int i = 0; i < scaleReqs; i++)
		begin
			r = randomReq();
			r.ixt.scale = i[1:0];
			r.ixt.zExt = i[2];
			sendReq(r, "scale");
		end

		// low and mid chunks near all ones, so carries ripple into the top
		for (int i = 0; i < carryReqs; i++)
		begin
			r = randomReq();
			r.base[31:0] = {16'hFFFF, 16'hFFF0 + 16'(i)};
			r.index = 64'(i * 5);
			r.ixt.scale = 2'b00;
			r.ixt.zExt = 1'b1;
			r.ixt.useDisp = 1'b1;
			r.imm = i[0] ? 16'hFFF6 : 16'h0030;
			sendReq(r, "carry");
		end

		for (int i = 0; i < enableReqs; i++)
		begin
			r = randomReq();
			r.enJq = (i < 4) ? 2'b00 : ((i < 8) ? 2'b10 : 2'b01);
			r.base[47:46] = i[0] ? 2'b11 : 2'b01;
			sendReq(r, "enable");
		end

		// every case as load, store and lea
		for (int i = 0; i < boundReqs; i++)
		begin
			r = boundReq(i / 3, (i % 3 == 0) ? cmdLoad : ((i % 3 == 1) ? cmdStore : cmdLea));
			sendReq(r, "bounds");
		end

		idleCycles(pipeLatency + 2);
		if (expQ.size() != 0)
		begin
			protocolErrors++;
			$display("%0d results never arrived", expQ.size());
		end
		$display("summary: %0d value errors, %0d protocol errors", valueErrors, protocolErrors);
		if (valueErrors == 0 && protocolErrors == 0)
		begin
			$display("ALL TESTS PASSED");
		end
		else
		begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* sources.f */
rtl/aguCfgPkg.sv
rtl/aguOpPkg.sv
rtl/aguStageReg.sv
rtl/aguIndexScale.sv
rtl/aguAddrAdd.sv
rtl/aguBoundCheck.sv
rtl/aguExecUnit.sv
testbench/tbClockGen.sv
testbench/tbAguExec.sv

/* Bender.yml */
package:
  name: agu_exec

sources:
  - rtl/aguCfgPkg.sv
  - rtl/aguOpPkg.sv
  - rtl/aguStageReg.sv
  - rtl/aguIndexScale.sv
  - rtl/aguAddrAdd.sv
  - rtl/aguBoundCheck.sv
  - rtl/aguExecUnit.sv
  - target: test
    files:
      - testbench/tbClockGen.sv
      - testbench/tbAguExec.sv
